// File: stepper_ctrl.f
src/stepper_pkg.sv
src/command_decoder.sv
src/move_sequencer.sv
src/dda_axis.sv
src/reply_builder.sv
src/stepper_ctrl.sv
test/stepper_ctrl_assertions.sv
test/tb_stepper_ctrl.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds and runs the stepper controller testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_stepper_ctrl \
  -f stepper_ctrl.f \
  -o sim_stepper_ctrl 2>&1 | tee build.log

# Assertion failures are counted by the testbench, so let the run reach its end
./obj_dir/sim_stepper_ctrl +verilator+error+limit+1000 2>&1 | tee sim.log

if grep -q "RESULT: FAIL" sim.log; then
  echo "Simulation failed, see sim.log"
  exit 1
fi
echo "Simulation passed"

// File: test/stepper_ctrl_golden.txt
# word_data reply enable brake done pos0 pos1 (hex except done, positions are 32-bit)
# done is the move_done count to reach before the word, positions checked when it changes
fd00000000000000 0000000000200002 0 0 0 00000000 00000000
fe00000000000000 0000000000000100 0 0 0 00000000 00000000
0000000000000000 0000000000000000 0 0 0 00000000 00000000
0a00000000000003 0000000000000000 3 0 0 00000000 00000000
0b00000000000001 0000000000000000 3 1 0 00000000 00000000
0100000000000003 0000000000000000 3 1 0 00000000 00000000
0000000000000008 0000000000000000 3 1 0 00000000 00000000
4000000000000000 0000000000000000 3 1 0 00000000 00000000
0000000000000000 0000000000000000 3 1 0 00000000 00000000
0000000000000000 0000000000000000 3 1 0 00000000 00000000
1000000000000000 0000000000000000 3 1 0 00000000 00000000
2000000000000004 0000000000000000 3 1 1 00000004 00000003
0100000000000000 0000000000000000 3 1 1 00000004 00000003
0000000000000040 0000000000000004 3 1 1 00000004 00000003
0000000000000000 0000000000000000 3 1 1 00000004 00000003
0000000000000000 0000000000000003 3 1 1 00000004 00000003
0000000000000000 0000000000000000 3 1 1 00000004 00000003
0000000000000000 0000000000000000 3 1 1 00000004 00000003
0100000000000002 0000000000000000 3 1 1 00000004 00000003
000000000000000c 0000000000000004 3 1 1 00000004 00000003
4000000000000000 0000000000000000 3 1 1 00000004 00000003
0000000000000000 0000000000000003 3 1 1 00000004 00000003
0000000000000000 0000000000000000 3 1 1 00000004 00000003
1000000000000000 0000000000000000 3 1 1 00000004 00000003
0b00000000000000 0000000000000000 3 0 3 fffffffe 00000009

// File: test/tb_stepper_ctrl.sv
// Golden file has two position columns so NUM_MOTORS must stay at 2
`timescale 1ns/100ps

module tb_stepper_ctrl;

  localparam int NUM_MOTORS = 2;
  localparam int BUFFER_SIZE = 2;

  logic                   CLK;
  logic                   resetn;
  stepper_pkg::word_t     word_data;
  logic                   word_received;
  stepper_pkg::word_t     word_send_data;
  logic [NUM_MOTORS-1:0]  step;
  logic [NUM_MOTORS-1:0]  dir;
  logic [NUM_MOTORS-1:0]  enable;
  logic [NUM_MOTORS-1:0]  brake;
  logic                   buffer_dtr;
  logic                   move_done;

  stepper_pkg::word_t     gold_word [$];
  stepper_pkg::word_t     gold_reply [$];
  logic [NUM_MOTORS-1:0]  gold_enable [$];
  logic [NUM_MOTORS-1:0]  gold_brake [$];
  int                     gold_done [$];
  stepper_pkg::position_t gold_pos0 [$];
  stepper_pkg::position_t gold_pos1 [$];
  int                     line_kind [$];   // 1 move header, 2 duration word
  int                     line_cycles [$]; // Duration times divisor
  logic [NUM_MOTORS-1:0]  dir_q [$];       // Expected dir of queued moves
  int                     len_q [$];
  int                     len_limit;
  int                     value_errors = 0;
  int                     other_errors = 0;
  int                     done_count = 0;
  int                     cycle = 0;
  int                     cycle_limit = 32'h7fff_ffff;
  int                     step_start = 0;
  logic                   measuring = 1'b0;
  logic                   dtr_low_seen = 1'b0;

  stepper_ctrl #(.NUM_MOTORS(NUM_MOTORS), .BUFFER_SIZE(BUFFER_SIZE)) u_stepper_ctrl (
    .CLK(CLK), .resetn(resetn), .word_data(word_data), .word_received(word_received),
    .word_send_data(word_send_data), .step(step), .dir(dir), .enable(enable),
    .brake(brake), .buffer_dtr(buffer_dtr), .move_done(move_done)
  );

  initial begin
    CLK = 1'b0;
    forever #10 CLK = ~CLK;
  end

  task automatic check_word(input string name, input stepper_pkg::word_t got,
                            input stepper_pkg::word_t expected);
    if (got !== expected) begin
      value_errors++;
      $display("error at %0t: %s is %h, expected %h", $time, name, got, expected);
    end
  endtask

  task automatic check_bits(input string name, input logic [NUM_MOTORS-1:0] got,
                            input logic [NUM_MOTORS-1:0] expected);
    if (got !== expected) begin
      value_errors++;
      $display("error at %0t: %s is %b, expected %b", $time, name, got, expected);
    end
  endtask

  task automatic check_position(input string name, input stepper_pkg::position_t got,
                                input stepper_pkg::position_t expected);
    if (got !== expected) begin
      value_errors++;
      $display("error at %0t: %s is %0d, expected %0d", $time, name, got, expected);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic expected);
    if (got !== expected) begin
      value_errors++;
      $display("error at %0t: %s is %b, expected %b", $time, name, got, expected);
    end
  endtask

  // Host handshake with 3 cycles high then 3 low before the reply is read
  task automatic send_word(input stepper_pkg::word_t w);
    @(posedge CLK);
    word_data     <= w;
    word_received <= 1'b1;
    repeat (3) @(posedge CLK);
    word_received <= 1'b0;
    repeat (3) @(posedge CLK);
    @(negedge CLK);
  endtask

  // Cycle limit, move_done count, dir and move length
  always @(posedge CLK) begin
    cycle = cycle + 1;
    if (cycle >= cycle_limit) begin
      $display("timeout: run did not finish within %0d cycles", cycle_limit);
      $display("RESULT: FAIL");
      $finish;
    end else begin
      if (buffer_dtr === 1'b0) dtr_low_seen = 1'b1;
      if (u_stepper_ctrl.running === 1'b1 && dir_q.size() > 0) begin
        check_bits("dir", dir, dir_q[0]);
      end
      if ((|step) === 1'b1 && !measuring) begin
        measuring  = 1'b1;
        step_start = cycle;
      end
      if (move_done === 1'b1) begin
        done_count++;
        if (len_q.size() == 0 || dir_q.size() == 0) begin
          other_errors++;
          $display("move_done pulsed at %0t with no move sent", $time);
        end else begin
          len_limit = len_q.pop_front() + 3;
          dir_q.delete(0);
          if (measuring && cycle - step_start > len_limit) begin
            other_errors++;
            $display("move ran %0d cycles after its first step, more than %0d allowed",
                     cycle - step_start, len_limit);
          end
        end
        measuring = 1'b0;
      end
    end
  end

  initial begin
    int                     fd;
    int                     n;
    string                  line;
    stepper_pkg::word_t     w;
    stepper_pkg::word_t     r;
    logic [NUM_MOTORS-1:0]  en;
    logic [NUM_MOTORS-1:0]  br;
    int                     dn;
    stepper_pkg::position_t p0;
    stepper_pkg::position_t p1;
    int                     move_left;
    logic                   api_pending;
    stepper_pkg::divisor_t  div;
    int                     budget;
    int                     moves;
    int                     last_done;

    resetn        = 1'b1;
    word_data     = '0;
    word_received = 1'b0;
    move_left     = 0;
    api_pending   = 1'b0;
    div           = stepper_pkg::DEFAULT_DIVISOR;
    budget        = 0;
    moves         = 0;
    fd = $fopen("test/stepper_ctrl_golden.txt", "r");
    if (fd == 0) begin
      other_errors++;
      $display("cannot open the golden file");
    end
    while (fd != 0 && !$feof(fd)) begin
      n = $fgets(line, fd);
      if (n < 2 || line[0] == "#") continue;
      if ($sscanf(line, "%h %h %h %h %d %h %h", w, r, en, br, dn, p0, p1) != 7) continue;
      gold_word.push_back(w);
      gold_reply.push_back(r);
      gold_enable.push_back(en);
      gold_brake.push_back(br);
      gold_done.push_back(dn);
      gold_pos0.push_back(p0);
      gold_pos1.push_back(p1);
      line_kind.push_back(0);
      line_cycles.push_back(0);
      budget += 20;
      // Track message framing to find headers and duration words
      if (api_pending) begin
        api_pending = 1'b0;
      end else if (move_left > 0) begin
        if (move_left == 2 * NUM_MOTORS + 1) begin
          line_kind[$]   = 2;
          line_cycles[$] = int'(w[31:0]) * int'(div);
          budget        += line_cycles[$];
        end
        move_left--;
      end else begin
        case (w[63:56])
          stepper_pkg::CMD_COORDINATED_STEP: begin
            line_kind[$] = 1;
            move_left    = 2 * NUM_MOTORS + 1;
            moves++;
          end
          stepper_pkg::CMD_API_VERSION: api_pending = 1'b1;
          stepper_pkg::CMD_CLK_DIVISOR: div = w[7:0];
          default: ;
        endcase
      end
    end
    if (fd != 0) $fclose(fd);
    cycle_limit = budget + 2; // Reset cycles on top

    repeat (2) @(posedge CLK);
    resetn <= 1'b0;
    @(negedge CLK);
    check_bits("step", step, '0);
    check_bits("enable", enable, '0);
    check_bits("brake", brake, '0);
    check_flag("buffer_dtr", buffer_dtr, 1'b1);
    check_flag("move_done", move_done, 1'b0);
    check_word("word_send_data", word_send_data, '0);

    last_done = 0;
    for (int i = 0; i < gold_word.size(); i++) begin
      while (done_count < gold_done[i]) @(negedge CLK);
      if (gold_done[i] != last_done) begin
        check_position("position[0]", u_stepper_ctrl.position[0], gold_pos0[i]);
        check_position("position[1]", u_stepper_ctrl.position[1], gold_pos1[i]);
        last_done = gold_done[i];
      end
      if (line_kind[i] == 1) begin
        check_flag("buffer_dtr", buffer_dtr, 1'b1); // Host sends a move only with a free slot
        dir_q.push_back(gold_word[i][NUM_MOTORS-1:0]);
      end
      if (line_kind[i] == 2) len_q.push_back(line_cycles[i]);
      send_word(gold_word[i]);
      check_word("word_send_data", word_send_data, gold_reply[i]);
      check_bits("enable", enable, gold_enable[i]);
      check_bits("brake", brake, gold_brake[i]);
    end

    if (!dtr_low_seen) begin
      other_errors++;
      $display("buffer_dtr never fell while both slots were full");
    end
    if (done_count != moves) begin
      other_errors++;
      $display("%0d move_done pulses seen for %0d moves", done_count, moves);
    end
    $display("errors: %0d wrong values, %0d other, %0d assertion", value_errors, other_errors,
             u_stepper_ctrl.u_move_sequencer.u_seq_assertions.fail_count);
    if (value_errors + other_errors
        + u_stepper_ctrl.u_move_sequencer.u_seq_assertions.fail_count == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: test/stepper_ctrl_assertions.sv
// Sequencer checks hold only when BUFFER_SIZE matches the bound move_sequencer
`timescale 1ns/100ps

module stepper_ctrl_assertions #(
  parameter int BUFFER_SIZE = 2,
  localparam int INDEX_BITS = (BUFFER_SIZE > 1) ? $clog2(BUFFER_SIZE) : 1
) (
  input logic                    CLK,
  input logic                    resetn,
  input logic                    move_done,
  input logic                    dda_tick,
  input stepper_pkg::divisor_t   divisor,
  input stepper_pkg::divisor_t   tick_count,
  input stepper_pkg::seq_state_e state,
  input logic [BUFFER_SIZE-1:0]  stepready,
  input logic [BUFFER_SIZE-1:0]  stepready_seen,
  input logic [INDEX_BITS-1:0]   move_index
);

  int fail_count = 0;

  done_one_cycle: assert property (@(posedge CLK) disable iff (resetn)
    move_done |=> !move_done)
    else begin
      $error("move_done held for more than one cycle");
      fail_count++;
    end

  // Each tick starts a new count of divisor cycles
  tick_reload: assert property (@(posedge CLK) disable iff (resetn)
    dda_tick && !resetn |=> tick_count == $past(divisor) - 8'd1)
    else begin
      $error("tick counter reloaded to %0d after a tick", tick_count);
      fail_count++;
    end

  // Load only a slot that the decoder has marked ready
  load_needs_ready: assert property (@(posedge CLK) disable iff (resetn)
    state == stepper_pkg::SEQ_LOAD |-> stepready[move_index] != stepready_seen[move_index])
    else begin
      $error("slot %0d loaded without being ready", move_index);
      fail_count++;
    end

  run_after_load: assert property (@(posedge CLK) disable iff (resetn)
    state == stepper_pkg::SEQ_RUN |->
      ($past(state) == stepper_pkg::SEQ_LOAD || $past(state) == stepper_pkg::SEQ_RUN))
    else begin
      $error("sequencer entered run without a load");
      fail_count++;
    end

endmodule

bind move_sequencer stepper_ctrl_assertions #(.BUFFER_SIZE(BUFFER_SIZE)) u_seq_assertions (
  .CLK(CLK), .resetn(resetn), .move_done(move_done), .dda_tick(dda_tick),
  .divisor(divisor), .tick_count(tick_count), .state(state), .stepready(stepready),
  .stepready_seen(stepready_seen), .move_index(move_index)
);

// File: src/stepper_ctrl.sv
// Host words on word_received edges and no back-pressure beyond buffer_dtr
`timescale 1ns/100ps

module stepper_ctrl #(
  parameter int NUM_MOTORS = 2,
  parameter int BUFFER_SIZE = 2,
  localparam int INDEX_BITS = (BUFFER_SIZE > 1) ? $clog2(BUFFER_SIZE) : 1,
  localparam int AXIS_BITS = (NUM_MOTORS > 1) ? $clog2(NUM_MOTORS) : 1
) (
  input  logic                  CLK,
  input  logic                  resetn,
  input  stepper_pkg::word_t    word_data,
  input  logic                  word_received,
  output stepper_pkg::word_t    word_send_data,
  output logic [NUM_MOTORS-1:0] step,
  output logic [NUM_MOTORS-1:0] dir,
  output logic [NUM_MOTORS-1:0] enable,
  output logic [NUM_MOTORS-1:0] brake,
  output logic                  buffer_dtr,
  output logic                  move_done
);

  logic [INDEX_BITS-1:0]   move_index;
  logic [BUFFER_SIZE-1:0]  stepready;
  stepper_pkg::duration_t  move_duration;
  stepper_pkg::dda_t       move_inc [NUM_MOTORS];
  stepper_pkg::dda_t       move_acc [NUM_MOTORS];
  stepper_pkg::divisor_t   divisor;
  stepper_pkg::reply_sel_e reply_sel;
  logic [AXIS_BITS-1:0]    reply_axis;
  logic                    reply_stb;
  logic                    snapshot_stb;
  logic                    dda_tick;
  logic                    load_move;
  logic                    running;
  stepper_pkg::position_t  position [NUM_MOTORS];

  command_decoder #(.NUM_MOTORS(NUM_MOTORS), .BUFFER_SIZE(BUFFER_SIZE)) u_command_decoder (
    .CLK(CLK), .resetn(resetn), .word_data(word_data), .word_received(word_received),
    .move_index(move_index), .stepready(stepready), .move_duration(move_duration),
    .move_inc(move_inc), .move_acc(move_acc), .dir(dir), .enable(enable), .brake(brake),
    .divisor(divisor), .reply_sel(reply_sel), .reply_axis(reply_axis),
    .reply_stb(reply_stb), .snapshot_stb(snapshot_stb)
  );

  move_sequencer #(.BUFFER_SIZE(BUFFER_SIZE)) u_move_sequencer (
    .CLK(CLK), .resetn(resetn), .divisor(divisor), .stepready(stepready),
    .move_duration(move_duration), .move_index(move_index), .dda_tick(dda_tick),
    .load_move(load_move), .running(running), .buffer_dtr(buffer_dtr), .move_done(move_done)
  );

  reply_builder #(.NUM_MOTORS(NUM_MOTORS)) u_reply_builder (
    .CLK(CLK), .resetn(resetn), .reply_sel(reply_sel), .reply_axis(reply_axis),
    .reply_stb(reply_stb), .snapshot_stb(snapshot_stb), .position(position),
    .word_send_data(word_send_data)
  );

  for (genvar m = 0; m < NUM_MOTORS; m++) begin : g_axis
    dda_axis u_dda_axis (
      .CLK(CLK), .resetn(resetn), .dda_tick(dda_tick), .load_move(load_move),
      .running(running), .move_inc(move_inc[m]), .move_acc(move_acc[m]), .dir(dir[m]),
      .step(step[m]), .position(position[m])
    );
  end

endmodule

// File: src/reply_builder.sv
// Reply word changes only on reply_stb and position replies show the snapshot at move start
`timescale 1ns/100ps

module reply_builder #(
  parameter int NUM_MOTORS = 2,
  localparam int AXIS_BITS = (NUM_MOTORS > 1) ? $clog2(NUM_MOTORS) : 1
) (
  input  logic                    CLK,
  input  logic                    resetn,
  input  stepper_pkg::reply_sel_e reply_sel,
  input  logic [AXIS_BITS-1:0]    reply_axis,
  input  logic                    reply_stb,
  input  logic                    snapshot_stb,
  input  stepper_pkg::position_t  position [NUM_MOTORS],
  output stepper_pkg::word_t      word_send_data
);

  stepper_pkg::position_t snapshot [NUM_MOTORS];
  stepper_pkg::word_t     info_word;
  stepper_pkg::word_t     version_word;

  // Channel info layout
  assign info_word = {
    40'd0,
    8'(stepper_pkg::POSITION_BITS), // Byte 2
    8'd0,                           // No encoders
    8'(NUM_MOTORS)
  };

  assign version_word = {
    32'd0,
    stepper_pkg::VERSION_DEVEL,
    stepper_pkg::VERSION_MAJOR,
    stepper_pkg::VERSION_MINOR,
    stepper_pkg::VERSION_PATCH
  };

  always_ff @(posedge CLK) begin
    if (snapshot_stb) begin
      for (int n = 0; n < NUM_MOTORS; n++) begin
        snapshot[n] <= position[n];
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (resetn) begin
      word_send_data <= '0;
    end else if (reply_stb) begin
      case (reply_sel)
        stepper_pkg::REPLY_INFO:     word_send_data <= info_word;
        stepper_pkg::REPLY_VERSION:  word_send_data <= version_word;
        stepper_pkg::REPLY_POSITION: word_send_data <= {32'd0, snapshot[reply_axis]};
        default:                     word_send_data <= '0;
      endcase
    end
  end

endmodule

// File: src/dda_axis.sv
// Accumulator restarts at zero on every move load so steps depend on the move words only
`timescale 1ns/100ps

module dda_axis (
  input  logic                   CLK,
  input  logic                   resetn,
  input  logic                   dda_tick,
  input  logic                   load_move,
  input  logic                   running,
  input  stepper_pkg::dda_t      move_inc,
  input  stepper_pkg::dda_t      move_acc,
  input  logic                   dir,
  output logic                   step,
  output stepper_pkg::position_t position
);

  localparam int TOP = stepper_pkg::DDA_BITS - 1;

  stepper_pkg::dda_t increment;    // Velocity term, grows by acceleration
  stepper_pkg::dda_t acceleration;
  stepper_pkg::dda_t accumulator;
  stepper_pkg::dda_t accumulator_next;
  logic              advance;
  logic              top_flip;

  assign accumulator_next = accumulator + increment;
  assign advance          = dda_tick & running;
  assign top_flip         = accumulator_next[TOP] != accumulator[TOP];

  always_ff @(posedge CLK) begin
    if (load_move) begin
      increment    <= move_inc;
      acceleration <= move_acc;
      accumulator  <= '0;
    end else if (advance) begin
      increment   <= increment + acceleration;
      accumulator <= accumulator_next;
    end
  end

  // One cycle step pulse per top bit change
  always_ff @(posedge CLK) begin
    if (resetn) begin
      step     <= 1'b0;
      position <= '0;
    end else begin
      step <= advance & top_flip;
      if (advance && top_flip) begin
        if (dir) begin
          position <= position + 32'sd1;
        end else begin
          position <= position - 32'sd1;
        end
      end
    end
  end

endmodule

// File: src/move_sequencer.sv
// Plays buffered moves in slot order and a zero duration move finishes without ticks
`timescale 1ns/100ps

module move_sequencer #(
  parameter int BUFFER_SIZE = 2,
  localparam int INDEX_BITS = (BUFFER_SIZE > 1) ? $clog2(BUFFER_SIZE) : 1
) (
  input  logic                   CLK,
  input  logic                   resetn,
  input  stepper_pkg::divisor_t  divisor,
  input  logic [BUFFER_SIZE-1:0] stepready,
  input  stepper_pkg::duration_t move_duration,
  output logic [INDEX_BITS-1:0]  move_index,
  output logic                   dda_tick,
  output logic                   load_move,
  output logic                   running,
  output logic                   buffer_dtr,
  output logic                   move_done
);

  stepper_pkg::seq_state_e state;
  logic [BUFFER_SIZE-1:0]  stepready_seen; // Sequencer copy of stepready
  logic [BUFFER_SIZE-1:0]  busy;
  stepper_pkg::divisor_t   tick_count;
  stepper_pkg::duration_t  ticks_left;

  assign dda_tick  = (tick_count == '0);
  assign load_move = (state == stepper_pkg::SEQ_LOAD);
  assign running   = (state == stepper_pkg::SEQ_RUN);

  // A slot is taken while it waits or while it plays
  always_comb begin
    busy = stepready ^ stepready_seen;
    if (state != stepper_pkg::SEQ_IDLE) begin
      busy[move_index] = 1'b1;
    end
  end

  assign buffer_dtr = ~&busy;

  // Free running tick divider
  always_ff @(posedge CLK) begin
    if (resetn) begin
      tick_count <= '0;
    end else if (dda_tick) begin
      tick_count <= divisor - 8'd1; // Divisor 1 ticks every cycle
    end else begin
      tick_count <= tick_count - 8'd1;
    end
  end

  always_ff @(posedge CLK) begin
    if (resetn) begin
      state          <= stepper_pkg::SEQ_IDLE;
      stepready_seen <= '0;
      move_index     <= '0;
      move_done      <= 1'b0;
    end else begin
      move_done <= 1'b0;
      case (state)
        stepper_pkg::SEQ_IDLE: begin
          if (stepready[move_index] != stepready_seen[move_index]) begin
            state <= stepper_pkg::SEQ_LOAD;
          end
        end
        stepper_pkg::SEQ_LOAD: begin
          stepready_seen[move_index] <= stepready[move_index];
          ticks_left                 <= move_duration;
          if (move_duration == '0) begin
            move_done  <= 1'b1;
            move_index <= move_index + 1'b1;
            state      <= stepper_pkg::SEQ_IDLE;
          end else begin
            state <= stepper_pkg::SEQ_RUN;
          end
        end
        stepper_pkg::SEQ_RUN: begin
          if (dda_tick) begin
            ticks_left <= ticks_left - 32'd1;
            if (ticks_left == 32'd1) begin // Last tick of this move
              move_done  <= 1'b1;
              move_index <= move_index + 1'b1;
              state      <= stepper_pkg::SEQ_IDLE;
            end
          end
        end
        default: state <= stepper_pkg::SEQ_IDLE;
      endcase
    end
  end

endmodule

// File: src/command_decoder.sv
// Host must keep buffer_dtr high before sending a move since a full buffer is overwritten
`timescale 1ns/100ps

module command_decoder #(
  parameter int NUM_MOTORS = 2,
  parameter int BUFFER_SIZE = 2,
  localparam int INDEX_BITS = (BUFFER_SIZE > 1) ? $clog2(BUFFER_SIZE) : 1,
  localparam int AXIS_BITS = (NUM_MOTORS > 1) ? $clog2(NUM_MOTORS) : 1
) (
  input  logic                      CLK,
  input  logic                      resetn,
  input  stepper_pkg::word_t        word_data,
  input  logic                      word_received,
  input  logic [INDEX_BITS-1:0]     move_index,
  output logic [BUFFER_SIZE-1:0]    stepready,
  output stepper_pkg::duration_t    move_duration,
  output stepper_pkg::dda_t         move_inc [NUM_MOTORS],
  output stepper_pkg::dda_t         move_acc [NUM_MOTORS],
  output logic [NUM_MOTORS-1:0]     dir,
  output logic [NUM_MOTORS-1:0]     enable,
  output logic [NUM_MOTORS-1:0]     brake,
  output stepper_pkg::divisor_t     divisor,
  output stepper_pkg::reply_sel_e   reply_sel,
  output logic [AXIS_BITS-1:0]      reply_axis,
  output logic                      reply_stb,
  output logic                      snapshot_stb
);

  logic                  word_received_q;
  logic                  word_rise;
  stepper_pkg::cmd_t     word_cmd;
  stepper_pkg::cmd_t     message_header; // Header of the message in progress
  logic [7:0]            word_count;     // Words of that message taken so far
  logic                  awaiting_more;
  logic                  in_move;
  logic [INDEX_BITS-1:0] write_index;

  // Move buffer, one slot per queued move
  stepper_pkg::duration_t duration_mem [BUFFER_SIZE];
  stepper_pkg::dda_t      inc_mem [BUFFER_SIZE][NUM_MOTORS];
  stepper_pkg::dda_t      acc_mem [BUFFER_SIZE][NUM_MOTORS];
  logic [NUM_MOTORS-1:0]  dir_mem [BUFFER_SIZE];

  assign word_rise = word_received & ~word_received_q;
  assign word_cmd  = word_data[stepper_pkg::WORD_BITS-1 -: stepper_pkg::CMD_BITS];

  assign in_move       = (message_header == stepper_pkg::CMD_COORDINATED_STEP);
  assign awaiting_more = in_move || (message_header == stepper_pkg::CMD_API_VERSION);

  // Slot under playback goes to the sequencer and axes
  assign move_duration = duration_mem[move_index];
  assign dir           = dir_mem[move_index];

  always_comb begin
    for (int n = 0; n < NUM_MOTORS; n++) begin
      move_inc[n] = inc_mem[move_index][n];
      move_acc[n] = acc_mem[move_index][n];
    end
  end

  always_ff @(posedge CLK) begin
    if (resetn) begin
      word_received_q <= 1'b1; // A word needs a low phase first
      message_header  <= '0;
      word_count      <= '0;
      write_index     <= '0;
      stepready       <= '0;
      enable          <= '0;
      brake           <= '0;
      divisor         <= stepper_pkg::DEFAULT_DIVISOR;
      reply_sel       <= stepper_pkg::REPLY_ZERO;
      reply_axis      <= '0;
      reply_stb       <= 1'b0;
      snapshot_stb    <= 1'b0;
      for (int b = 0; b < BUFFER_SIZE; b++) begin
        dir_mem[b] <= '0;
      end
    end else begin
      word_received_q <= word_received;
      reply_stb       <= word_rise;
      snapshot_stb    <= 1'b0;
      if (word_rise) begin
        reply_sel  <= stepper_pkg::REPLY_ZERO; // Default reply
        reply_axis <= '0;
        if (!awaiting_more) begin
          message_header <= word_cmd;
          word_count     <= 8'd1;
          case (word_cmd)
            stepper_pkg::CMD_COORDINATED_STEP: begin
              dir_mem[write_index] <= word_data[NUM_MOTORS-1:0];
              snapshot_stb         <= 1'b1; // Positions at start of this move
            end
            stepper_pkg::CMD_MOTOR_ENABLE: enable <= word_data[NUM_MOTORS-1:0];
            stepper_pkg::CMD_MOTOR_BRAKE:  brake <= word_data[NUM_MOTORS-1:0];
            stepper_pkg::CMD_CLK_DIVISOR:  divisor <= word_data[stepper_pkg::DIVISOR_BITS-1:0];
            stepper_pkg::CMD_CHANNEL_INFO: reply_sel <= stepper_pkg::REPLY_INFO;
            stepper_pkg::CMD_API_VERSION:  reply_sel <= stepper_pkg::REPLY_VERSION;
            default: ;
          endcase
        end else if (in_move) begin
          word_count <= word_count + 8'd1;
          if (word_count == 8'd1) begin
            reply_sel <= stepper_pkg::REPLY_POSITION; // Axis 0 with the duration word
          end
          for (int n = 0; n < NUM_MOTORS; n++) begin
            if (word_count == 8'(2 * n + 3)) begin
              if (n < NUM_MOTORS - 1) begin
                reply_sel  <= stepper_pkg::REPLY_POSITION;
                reply_axis <= AXIS_BITS'(n + 1);
              end else begin
                // Last acceleration word hands the slot over
                stepready[write_index] <= ~stepready[write_index];
                write_index            <= write_index + 1'b1;
                message_header         <= '0;
                word_count             <= '0;
              end
            end
          end
        end else begin
          message_header <= '0; // Trailing API version word
          word_count     <= '0;
        end
      end
    end
  end

  // Buffer payload
  always_ff @(posedge CLK) begin
    if (word_rise && in_move) begin
      if (word_count == 8'd1) begin
        duration_mem[write_index] <= word_data[stepper_pkg::DURATION_BITS-1:0];
      end
      for (int n = 0; n < NUM_MOTORS; n++) begin
        if (word_count == 8'(2 * n + 2)) inc_mem[write_index][n] <= word_data;
        if (word_count == 8'(2 * n + 3)) acc_mem[write_index][n] <= word_data;
      end
    end
  end

endmodule

// File: src/stepper_pkg.sv
// Widths and codes shared by all controller blocks. Positions wrap silently at 32 bits
package stepper_pkg;

  localparam int WORD_BITS     = 64;
  localparam int CMD_BITS      = 8;
  localparam int DURATION_BITS = 32;
  localparam int DDA_BITS      = 64;
  localparam int POSITION_BITS = 32;
  localparam int DIVISOR_BITS  = 8;

  typedef logic        [WORD_BITS-1:0]     word_t;     // Host command or reply word
  typedef logic        [CMD_BITS-1:0]      cmd_t;      // Header byte in bits 63:56
  typedef logic        [DURATION_BITS-1:0] duration_t; // Move length in ticks
  typedef logic signed [DDA_BITS-1:0]      dda_t;      // Increment or acceleration
  typedef logic signed [POSITION_BITS-1:0] position_t;
  typedef logic        [DIVISOR_BITS-1:0]  divisor_t;

  // Host command codes
  localparam cmd_t CMD_COORDINATED_STEP = 8'h01;
  localparam cmd_t CMD_MOTOR_ENABLE     = 8'h0a;
  localparam cmd_t CMD_MOTOR_BRAKE      = 8'h0b;
  localparam cmd_t CMD_CLK_DIVISOR      = 8'h20;
  localparam cmd_t CMD_CHANNEL_INFO     = 8'hfd;
  localparam cmd_t CMD_API_VERSION      = 8'hfe;

  localparam divisor_t DEFAULT_DIVISOR = 8'd32; // CLK cycles per DDA tick

  // Reported by the API version command
  localparam logic [7:0] VERSION_MAJOR = 8'd0;
  localparam logic [7:0] VERSION_MINOR = 8'd1;
  localparam logic [7:0] VERSION_PATCH = 8'd0;
  localparam logic [7:0] VERSION_DEVEL = 8'd0;

  typedef enum logic [2:0] {
    REPLY_ZERO,
    REPLY_INFO,
    REPLY_VERSION,
    REPLY_POSITION
  } reply_sel_e;

  typedef enum logic [1:0] {
    SEQ_IDLE,
    SEQ_LOAD,
    SEQ_RUN
  } seq_state_e;

endpackage
